// File: common/sonar_settings.svh
`ifndef SONAR_SETTINGS_SVH
`define SONAR_SETTINGS_SVH

// samples summed into one energy window
`define SONAR_WINDOW_SIZE 64

// listening steps before the measurement gives up
// keep this a multiple of the window size
`define SONAR_MAX_DELAY 512

// length of the ping burst in steps
`define SONAR_PING_STEPS 8

// speaker amplitude while the ping is on
`define SONAR_PING_AMP 16'sd12000

// step counts, wide enough for the maximum delay
`define SONAR_STEP_W 10

// one window sum, 64 samples of at most 128 each
`define SONAR_ENERGY_W 16

`endif

// File: common/sonar_pkg.sv
`default_nettype none

`include "sonar_settings.svh"

package sonar_pkg;

  // top level sequencing
  typedef enum logic [1:0] {
    IDLE,
    PINGING,
    LISTENING
  } ranger_state_t;

  typedef logic [`SONAR_STEP_W-1:0] step_count_t;      // listening steps since the ping ended

  typedef logic [`SONAR_ENERGY_W-1:0] energy_t;        // sum of |sample| over a window

  // verdict on one finished window
  typedef struct packed {
    energy_t     energy;      // completed window sum
    logic        onset;       // rising energy rule met
    step_count_t start_step;  // step of the first sample in the window
  } window_report_t;

  // one finished measurement
  typedef struct packed {
    step_count_t distance;    // all ones on timeout
    logic        timeout;
  } range_result_t;

endpackage

`default_nettype wire

// File: source/ping_generator.sv
`default_nettype none

`include "sonar_settings.svh"

module ping_generator (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               step_in,
  input  logic               fire,
  output logic signed [15:0] amp_out,
  output logic               ping_done
);

  localparam int CNT_W = $clog2(`SONAR_PING_STEPS + 1);

  logic [CNT_W-1:0] steps_left;   // ping samples still to send
  logic             running;

  assign running = (steps_left != '0);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      steps_left <= '0;
      amp_out    <= '0;
      ping_done  <= 1'b0;
    end else begin
      ping_done <= 1'b0;        // single cycle pulse
      if (fire) begin
        steps_left <= CNT_W'(`SONAR_PING_STEPS);
      end else if (step_in) begin
        if (running) begin
          amp_out    <= `SONAR_PING_AMP;
          steps_left <= steps_left - CNT_W'(1);
          // this step sends the last sample of the burst
          if (steps_left == CNT_W'(1)) begin
            ping_done <= 1'b1;
          end
        end else begin
          amp_out <= '0;        // silent between pings
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ranging/echo_timer.sv
`default_nettype none

`include "sonar_settings.svh"

module echo_timer (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   step_in,
  input  logic                   listen,
  output logic                   window_end,
  output sonar_pkg::step_count_t window_start_step,
  output logic                   timed_out
);

  import sonar_pkg::*;

  localparam int WIN   = `SONAR_WINDOW_SIZE;
  localparam int IDX_W = $clog2(WIN);

  logic             listen_q;
  logic             listen_rise;
  logic             listen_step;
  step_count_t      elapsed;        // number of the current sample
  step_count_t      win_start;
  logic [IDX_W-1:0] idx;            // position inside the window

  assign listen_rise = listen & ~listen_q;
  assign listen_step = listen & step_in & ~listen_rise;

  // qualifiers for the sample arriving on this step
  assign window_end        = listen_step && (idx == IDX_W'(WIN - 1));
  assign timed_out         = window_end && (elapsed == step_count_t'(`SONAR_MAX_DELAY - 1));
  assign window_start_step = win_start;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      listen_q  <= 1'b0;
      elapsed   <= '0;
      win_start <= '0;
      idx       <= '0;
    end else begin
      listen_q <= listen;
      if (listen_rise) begin          // new measurement
        elapsed   <= '0;
        win_start <= '0;
        idx       <= '0;
      end else if (listen_step) begin
        elapsed <= elapsed + step_count_t'(1);
        if (window_end) begin
          idx       <= '0;
          win_start <= elapsed + step_count_t'(1);   // next window opens on the next sample
        end else begin
          idx <= idx + IDX_W'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ranging/window_energy.sv
`default_nettype none

`include "sonar_settings.svh"

module window_energy (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      step_in,
  input  logic                      listen,
  input  logic signed [7:0]         mic_in,
  input  logic                      window_end,
  input  sonar_pkg::step_count_t    window_start_step,
  output sonar_pkg::window_report_t report,
  output logic                      report_valid
);

  import sonar_pkg::*;

  logic                     listen_q;
  logic                     listen_rise;
  logic [7:0]               mic_bits;
  logic [7:0]               mag;          // 0 to 128
  energy_t                  acc;          // partial sum of the open window
  energy_t                  sum_now;      // sum including this sample
  energy_t                  prev_e;       // last finished window
  energy_t                  prev2_e;      // the one before that
  logic [`SONAR_ENERGY_W:0] thresh;       // 1.5 times prev2_e, one bit of headroom
  logic                     onset;

  assign listen_rise = listen & ~listen_q;

  // two's complement magnitude, -128 comes out as 128 in eight unsigned bits
  assign mic_bits = mic_in;
  assign mag      = mic_bits[7] ? (~mic_bits + 8'd1) : mic_bits;
  assign sum_now  = acc + energy_t'(mag);

  assign thresh = {1'b0, prev2_e} + {1'b0, (prev2_e >> 1)};
  assign onset  = (sum_now > prev_e) && ({1'b0, sum_now} > thresh);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      listen_q     <= 1'b0;
      report_valid <= 1'b0;
    end else begin
      listen_q     <= listen;
      report_valid <= window_end;   // one cycle after the closing step
    end
  end

  // running sum and window history
  always_ff @(posedge clk_in) begin
    if (listen_rise) begin
      acc     <= '0;
      prev_e  <= '0;
      prev2_e <= '0;
    end else if (listen && step_in) begin
      if (window_end) begin
        acc     <= '0;
        prev_e  <= sum_now;
        prev2_e <= prev_e;
      end else begin
        acc <= sum_now;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (window_end) begin
      report.energy     <= sum_now;
      report.onset      <= onset;
      report.start_step <= window_start_step;
    end
  end

endmodule

`default_nettype wire

// File: ranging/ranging_fsm.sv
`default_nettype none

module ranging_fsm (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      trigger,
  input  logic                      ping_done,
  input  sonar_pkg::window_report_t report,
  input  logic                      report_valid,
  input  logic                      timed_out,
  output logic                      fire,
  output logic                      listen,
  output logic                      busy,
  output sonar_pkg::ranger_state_t  state,
  output sonar_pkg::range_result_t  result,
  output logic                      result_valid
);

  import sonar_pkg::*;

  ranger_state_t cur_state;
  logic          timeout_seen;   // last allowed window has closed

  assign state  = cur_state;
  assign listen = (cur_state == LISTENING);
  assign busy   = (cur_state != IDLE);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cur_state    <= IDLE;
      fire         <= 1'b0;
      result_valid <= 1'b0;
      timeout_seen <= 1'b0;
      result       <= '0;
    end else begin
      fire         <= 1'b0;
      result_valid <= 1'b0;
      case (cur_state)
        IDLE: begin
          if (trigger) begin
            fire         <= 1'b1;
            timeout_seen <= 1'b0;
            cur_state    <= PINGING;
          end
        end

        PINGING: begin
          if (ping_done) begin
            cur_state <= LISTENING;   // timer and energy block clear on this edge
          end
        end

        LISTENING: begin
          // held until the report of the same window arrives
          if (timed_out) begin
            timeout_seen <= 1'b1;
          end
          if (report_valid) begin
            if (report.onset) begin
              result.distance <= report.start_step;
              result.timeout  <= 1'b0;
              result_valid    <= 1'b1;
              cur_state       <= IDLE;
            end else if (timeout_seen) begin
              result.distance <= '1;      // saturated range
              result.timeout  <= 1'b1;
              result_valid    <= 1'b1;
              cur_state       <= IDLE;
            end
          end
        end

        default: begin
          cur_state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/sonar_ranger_top.sv
`default_nettype none

module sonar_ranger_top (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     step_in,
  input  logic                     trigger,
  input  logic signed [7:0]        mic_in,
  output logic signed [15:0]       amp_out,
  output sonar_pkg::range_result_t result,
  output logic                     result_valid,
  output logic                     busy,
  output sonar_pkg::ranger_state_t state
);

  import sonar_pkg::*;

  logic           fire;
  logic           ping_done;
  logic           listen;
  logic           window_end;
  logic           timed_out;
  step_count_t    window_start_step;
  window_report_t report;
  logic           report_valid;

  ping_generator ping_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .step_in   (step_in),
    .fire      (fire),
    .amp_out   (amp_out),
    .ping_done (ping_done)
  );

  ranging_fsm fsm_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .trigger      (trigger),
    .ping_done    (ping_done),
    .report       (report),
    .report_valid (report_valid),
    .timed_out    (timed_out),
    .fire         (fire),
    .listen       (listen),
    .busy         (busy),
    .state        (state),
    .result       (result),
    .result_valid (result_valid)
  );

  echo_timer timer_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .step_in           (step_in),
    .listen            (listen),
    .window_end        (window_end),
    .window_start_step (window_start_step),
    .timed_out         (timed_out)
  );

  window_energy energy_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .step_in           (step_in),
    .listen            (listen),
    .mic_in            (mic_in),
    .window_end        (window_end),
    .window_start_step (window_start_step),
    .report            (report),
    .report_valid      (report_valid)
  );

endmodule

`default_nettype wire

// File: verification/sonar_ranger_tb.sv
`default_nettype none

`include "sonar_settings.svh"

module sonar_ranger_tb;

  import sonar_pkg::*;

  localparam int WIN        = `SONAR_WINDOW_SIZE;
  localparam int MAX_DELAY  = `SONAR_MAX_DELAY;
  localparam int NUM_WIN    = MAX_DELAY / WIN;
  localparam int PING_STEPS = `SONAR_PING_STEPS;
  localparam int STEP_CLKS  = 8;
  localparam int WAIT_LIMIT = (PING_STEPS + MAX_DELAY + 4) * STEP_CLKS + 50;
  localparam logic signed [15:0] PING_AMP = `SONAR_PING_AMP;

  logic               clk_in;
  logic               rst_in;
  logic               step_in;
  logic               trigger;
  logic signed [7:0]  mic_in;
  logic signed [15:0] amp_out;
  range_result_t      result;
  logic               result_valid;
  logic               busy;
  ranger_state_t      state;

  logic signed [7:0] mic_samples [0:MAX_DELAY-1];  // one sample per listening step
  logic              win_fires [0:NUM_WIN-1];     // onset rule met by this window

  int     steps_seen    = 0;
  int     checks        = 0;
  int     errors        = 0;
  int     tests_run     = 0;
  int     tests_failed  = 0;
  int     errors_before = 0;
  integer seed          = 5427;

  sonar_ranger_top dut_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .step_in      (step_in),
    .trigger      (trigger),
    .mic_in       (mic_in),
    .amp_out      (amp_out),
    .result       (result),
    .result_valid (result_valid),
    .busy         (busy),
    .state        (state)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // step strobe every 8 clocks and mic samples by listening step
  initial begin : step_driver
    int            phase;
    int            sample_idx;
    ranger_state_t state_prev;
    step_in    = 1'b0;
    mic_in     = '0;
    phase      = 0;
    sample_idx = 0;
    state_prev = IDLE;
    forever begin
      @(negedge clk_in);
      phase   = (phase + 1) % STEP_CLKS;
      step_in = (phase == 0);
      if (state != LISTENING) begin
        sample_idx = 0;
        mic_in     = '0;
      end else if (step_in && state_prev == LISTENING) begin
        // a step in the cycle that listening starts is not a sample
        mic_in     = (sample_idx < MAX_DELAY) ? mic_samples[sample_idx] : 8'sd0;
        sample_idx = sample_idx + 1;
      end
      state_prev = state;
    end
  end

  always @(posedge clk_in) begin
    if (step_in) begin
      steps_seen <= steps_seen + 1;
    end
  end

  task automatic check_result(input range_result_t got, input range_result_t exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: distance %0d timeout %b, expected distance %0d timeout %b",
               $time, what, got.distance, got.timeout, exp.distance, exp.timeout);
    end
  endtask

  task automatic check_state(input ranger_state_t got, input ranger_state_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: state %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_amp(input logic signed [15:0] got, input logic signed [15:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: amp %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic int magnitude(input logic signed [7:0] s);
    int v;
    v = s;
    return (v < 0) ? -v : v;
  endfunction

  // window sums and the onset rule over the whole sample array
  task automatic model_range(output range_result_t exp);
    int   e_cur;
    int   e_prev;
    int   e_prev2;
    int   w;
    int   k;
    logic found;
    e_prev       = 0;
    e_prev2      = 0;
    found        = 1'b0;
    exp.distance = '1;
    exp.timeout  = 1'b1;
    for (w = 0; w < NUM_WIN; w++) begin
      e_cur = 0;
      for (k = 0; k < WIN; k++) begin
        e_cur += magnitude(mic_samples[w * WIN + k]);
      end
      win_fires[w] = (e_cur > e_prev) && (2 * e_cur > 3 * e_prev2);   // above 1.5x
      if (win_fires[w] && !found) begin
        found        = 1'b1;
        exp.distance = step_count_t'(w * WIN);
        exp.timeout  = 1'b0;
      end
      e_prev2 = e_prev;
      e_prev  = e_cur;
    end
  endtask

  task automatic fill_echo(input int start, input logic signed [7:0] amp);
    int k;
    for (k = 0; k < MAX_DELAY; k++) begin
      mic_samples[k] = (k >= start) ? amp : 8'sd0;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_in);
    rst_in  = 1'b1;
    trigger = 1'b0;
    repeat (2) @(negedge clk_in);
    rst_in = 1'b0;
  endtask

  task automatic pulse_trigger();
    @(negedge clk_in);
    trigger = 1'b1;
    @(negedge clk_in);
    trigger = 1'b0;
  endtask

  task automatic start_measurement();
    pulse_trigger();
    check_flag(busy, 1'b1, "busy after trigger");
  endtask

  task automatic finish_measurement(output range_result_t res, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge clk_in);
      n++;
      ok = (result_valid === 1'b1);
    end
    res = result;
    if (!ok) begin
      errors++;
      $display("timeout: no result from the DUT after %0d clock cycles", n);
    end else begin
      check_flag(busy, 1'b0, "busy with result_valid");
      check_state(state, IDLE, "state with result_valid");
    end
  endtask

  task automatic wait_state(input ranger_state_t target);
    int n;
    n = 0;
    while (state !== target && n < WAIT_LIMIT) begin
      @(negedge clk_in);
      n++;
    end
    if (state !== target) begin
      errors++;
      $display("timeout: state never reached %s within %0d cycles", target.name(), n);
    end
  endtask

  task automatic begin_test();
    tests_run++;
    errors_before = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  task automatic test_reset_ping();
    range_result_t      got;
    logic               ok;
    logic signed [15:0] exp_amp;
    int                 base;
    int                 n;
    int                 guard;
    begin_test();
    apply_reset();
    check_state(state, IDLE, "state after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(result_valid, 1'b0, "result_valid after reset");
    check_amp(amp_out, 16'sd0, "amp after reset");
    check_result(result, '0, "result after reset");
    fill_echo(MAX_DELAY, 8'sd0);
    start_measurement();
    @(negedge clk_in);          // fire has reached the ping generator
    base  = steps_seen;
    n     = 0;
    guard = 0;
    while (n <= PING_STEPS + 1 && guard < (PING_STEPS + 4) * STEP_CLKS) begin
      exp_amp = (n >= 1 && n <= PING_STEPS) ? PING_AMP : 16'sd0;
      check_amp(amp_out, exp_amp, "ping amplitude");
      if (n < PING_STEPS) begin
        check_state(state, PINGING, "state during ping");
      end else if (n > PING_STEPS) begin
        check_state(state, LISTENING, "state after ping");
      end
      @(negedge clk_in);
      guard++;
      n = steps_seen - base;
    end
    if (n <= PING_STEPS + 1) begin
      errors++;
      $display("timeout: the ping did not run through its steps");
    end
    finish_measurement(got, ok);
    end_test("reset and ping shape");
  endtask

  task automatic test_clean_echo();
    int            echo_at [5] = '{0, 37, 64, 200, 450};
    range_result_t exp;
    range_result_t got;
    logic          ok;
    int            i;
    begin_test();
    apply_reset();
    for (i = 0; i < 5; i++) begin
      fill_echo(echo_at[i], 8'sd60);
      exp.distance = step_count_t'((echo_at[i] / WIN) * WIN);
      exp.timeout  = 1'b0;
      start_measurement();
      finish_measurement(got, ok);
      if (ok) begin
        check_result(got, exp, $sformatf("clean echo at step %0d", echo_at[i]));
      end
    end
    end_test("clean echo");
  endtask

  task automatic test_noise_echo();
    range_result_t exp;
    range_result_t got;
    logic          ok;
    int            echo_w;
    int            k;
    int            w;
    begin_test();
    apply_reset();
    echo_w = 5;
    for (k = 0; k < MAX_DELAY; k++) begin
      if (k < echo_w * WIN) begin
        mic_samples[k] = ($random(seed) & 1) ? 8'sd20 : -8'sd20;   // flat window sums
      end else begin
        mic_samples[k] = ($random(seed) & 1) ? 8'sd100 : -8'sd100;
      end
    end
    model_range(exp);
    // window 0 rises from the cleared history and the flat ones after it must not
    for (w = 1; w < echo_w; w++) begin
      check_flag(win_fires[w], 1'b0, $sformatf("model, flat noise window %0d", w));
    end
    check_flag(win_fires[echo_w], 1'b1, "model, echo window");
    start_measurement();
    finish_measurement(got, ok);
    if (ok) begin
      check_result(got, exp, "echo in steady noise");
    end
    end_test("echo in steady noise");
  endtask

  task automatic test_timeout();
    range_result_t exp;
    range_result_t model;
    range_result_t got;
    logic          ok;
    begin_test();
    apply_reset();
    fill_echo(MAX_DELAY, 8'sd0);
    exp.distance = '1;
    exp.timeout  = 1'b1;
    model_range(model);
    check_result(model, exp, "model for silence");
    start_measurement();
    finish_measurement(got, ok);
    if (ok) begin
      check_result(got, exp, "silence");
    end
    end_test("timeout");
  endtask

  task automatic test_retrigger();
    range_result_t first;
    range_result_t second;
    range_result_t exp;
    logic          ok;
    begin_test();
    apply_reset();
    fill_echo(130, 8'sd50);
    start_measurement();
    pulse_trigger();
    check_state(state, PINGING, "trigger while pinging");
    wait_state(LISTENING);
    pulse_trigger();
    check_state(state, LISTENING, "trigger while listening");
    finish_measurement(first, ok);
    exp.distance = step_count_t'(128);
    exp.timeout  = 1'b0;
    check_result(first, exp, "first measurement");
    repeat (40) @(negedge clk_in);
    check_result(result, exp, "result held while idle");
    fill_echo(300, -8'sd70);
    start_measurement();
    check_result(result, exp, "result held into next ping");
    finish_measurement(second, ok);
    exp.distance = step_count_t'(256);
    check_result(second, exp, "second measurement");
    end_test("busy and retrigger");
  endtask

  task automatic test_negative_extreme();
    int            echo_at [2] = '{200, 256};
    range_result_t exp;
    range_result_t got;
    logic          ok;
    int            i;
    begin_test();
    apply_reset();
    for (i = 0; i < 2; i++) begin
      fill_echo(echo_at[i], -8'sd128);
      model_range(exp);
      start_measurement();
      finish_measurement(got, ok);
      if (ok) begin
        check_result(got, exp, $sformatf("-128 echo at step %0d", echo_at[i]));
      end
    end
    end_test("negative extreme");
  endtask

  initial begin
    rst_in  = 1'b1;
    trigger = 1'b0;
    test_reset_ping();
    test_clean_echo();
    test_noise_echo();
    test_timeout();
    test_retrigger();
    test_negative_extreme();
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/sonar_pkg.sv
source/ping_generator.sv
ranging/echo_timer.sv
ranging/window_energy.sv
ranging/ranging_fsm.sv
source/sonar_ranger_top.sv
verification/sonar_ranger_tb.sv

// File: Bender.yml
package:
  name: sonar_ranger

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sonar_pkg.sv
      - source/ping_generator.sv
      - ranging/echo_timer.sv
      - ranging/window_energy.sv
      - ranging/ranging_fsm.sv
      - source/sonar_ranger_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/sonar_ranger_tb.sv
